// ==== Bender.yml ====
package:
  name: frame_top

sources:
  - src/frame_pkg.sv
  - src/spi_subperipheral_if.sv
  - src/spi_peripheral.sv
  - src/spi_subperipheral_selector.sv
  - src/spi_register_version_string.sv
  - src/display.sv
  - src/top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_top_sva.sv
      - verif/tb_top.sv

// ==== src/display.sv ====
`timescale 1ns/1ps

module display #(
    parameter logic [15:0] H_ACTIVE = 16'd640,
    parameter logic [15:0] H_FRONT  = 16'd16,
    parameter logic [15:0] H_SYNC   = 16'd96,
    parameter logic [15:0] H_BACK   = 16'd48,
    parameter logic [15:0] V_ACTIVE = 16'd400,
    parameter logic [15:0] V_FRONT  = 16'd12,
    parameter logic [15:0] V_SYNC   = 16'd2,
    parameter logic [15:0] V_BACK   = 16'd35
) (
    input  logic       clock,
    input  logic       rst,
    output logic       display_clock,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] y,
    output logic [2:0] cr,
    output logic [2:0] cb
);

    localparam logic [15:0] H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam logic [15:0] V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    logic [15:0] h_count;
    logic [15:0] v_count;
    logic [15:0] pattern_sum;
    logic        active;
    logic        h_sync_zone;
    logic        v_sync_zone;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel clock and timing counters

    always_ff @(posedge clock) begin
        if (rst) begin
            display_clock <= 1'b0;
            h_count       <= '0;
            v_count       <= '0;
        end else begin
            display_clock <= !display_clock;
            if (display_clock) begin // Once per pixel period
                if (h_count == H_TOTAL - 16'd1) begin
                    h_count <= '0;
                    if (v_count == V_TOTAL - 16'd1) begin
                        v_count <= '0;
                    end else begin
                        v_count <= v_count + 16'd1;
                    end
                end else begin
                    h_count <= h_count + 16'd1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sync and test pattern outputs

    assign active      = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
    assign h_sync_zone = (h_count >= H_ACTIVE + H_FRONT) &&
                         (h_count <  H_ACTIVE + H_FRONT + H_SYNC);
    assign v_sync_zone = (v_count >= V_ACTIVE + V_FRONT) &&
                         (v_count <  V_ACTIVE + V_FRONT + V_SYNC);
    assign pattern_sum = h_count + v_count;

    always_ff @(posedge clock) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            y     <= '0;
            cr    <= '0;
            cb    <= '0;
        end else begin
            hsync <= !h_sync_zone; // Both syncs are active low
            vsync <= !v_sync_zone;
            if (active) begin
                y  <= h_count[3:0];
                cr <= v_count[2:0];
                cb <= pattern_sum[2:0];
            end else begin
                y  <= '0;
                cr <= '0;
                cb <= '0;
            end
        end
    end

endmodule

// ==== src/frame_pkg.sv ====
package frame_pkg;

    // One byte on the SPI wire
    typedef logic [7:0] spi_byte_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Subperipheral address map

    localparam spi_byte_t SPI_ADDR_CHIP_ID = 8'hDB;
    localparam spi_byte_t SPI_ADDR_VERSION = 8'hB5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register contents

    localparam spi_byte_t CHIP_ID = 8'h81;

    localparam int VERSION_LENGTH = 4;

    // The first character sits in the top byte, as a string literal packs it
    localparam logic [VERSION_LENGTH*8-1:0] VERSION_STRING = "v1.0";

endpackage

// ==== src/spi_peripheral.sv ====
`timescale 1ns/1ps

module spi_peripheral (
    input  logic clock,
    input  logic rst,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out,
    spi_subperipheral_if.peripheral bus
);

    logic [1:0]           select_sync;
    logic [1:0]           sclk_sync;
    logic [1:0]           data_sync;
    logic                 sclk_prev;
    logic                 selected;
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic [2:0]           bit_count;
    frame_pkg::spi_byte_t rx_shift;
    frame_pkg::spi_byte_t rx_byte;
    frame_pkg::spi_byte_t tx_shift;
    logic                 byte_done;
    logic                 load_tx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin synchronisers and edge detection

    always_ff @(posedge clock) begin
        if (rst) begin
            select_sync <= 2'b11; // Idle is deselected
            sclk_sync   <= 2'b00;
            data_sync   <= 2'b00;
            sclk_prev   <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            sclk_sync   <= {sclk_sync[0], spi_clock};
            data_sync   <= {data_sync[0], spi_data_in};
            sclk_prev   <= sclk_sync[1];
        end
    end

    assign selected  = !select_sync[1];
    assign sclk_rise = selected && sclk_sync[1] && !sclk_prev;
    assign sclk_fall = selected && !sclk_sync[1] && sclk_prev;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive path

    assign rx_byte = {rx_shift[6:0], data_sync[1]};

    always_ff @(posedge clock) begin
        if (rst) begin
            bit_count         <= 3'd0;
            bus.address_valid <= 1'b0;
            bus.copi_valid    <= 1'b0;
            byte_done         <= 1'b0;
        end else begin
            bus.copi_valid <= 1'b0;
            byte_done      <= 1'b0;
            if (!selected) begin
                bit_count         <= 3'd0;
                bus.address_valid <= 1'b0;
            end else if (sclk_rise) begin
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    byte_done <= 1'b1;
                    // First byte of a transaction is always the address
                    if (bus.address_valid) begin
                        bus.copi_valid <= 1'b1;
                    end else begin
                        bus.address_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            rx_shift <= rx_byte;
            if (bit_count == 3'd7 && !bus.address_valid) begin
                bus.address <= rx_byte;
            end
            if (bit_count == 3'd7 && bus.address_valid) begin
                bus.copi <= rx_byte;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit path

    // The load waits one clock after copi_valid so a register can step its index first
    always_ff @(posedge clock) begin
        if (rst) begin
            load_tx  <= 1'b0;
            tx_shift <= '0;
        end else begin
            load_tx <= byte_done;
            if (!selected) begin
                tx_shift <= '0;
            end else if (load_tx) begin
                tx_shift <= bus.cipo_valid ? bus.cipo : 8'h00;
            end else if (sclk_fall && bit_count != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0}; // MSB of a fresh byte is already out
            end
        end
    end

    assign spi_data_out = tx_shift[7] && !spi_select; // Line released while deselected

endmodule

// ==== src/spi_register_version_string.sv ====
`timescale 1ns/1ps

module spi_register_version_string (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 copi_valid,
    output frame_pkg::spi_byte_t data,
    output logic                 data_valid
);

    localparam int INDEX_WIDTH = $clog2(frame_pkg::VERSION_LENGTH + 1);

    logic [INDEX_WIDTH-1:0] index;

    // Index saturates at the end of the string so it never wraps back to the start
    always_ff @(posedge clock) begin
        if (rst || !enable) begin
            index <= '0;
        end else if (copi_valid && index < frame_pkg::VERSION_LENGTH) begin
            index <= index + 1'b1;
        end
    end

    always_comb begin
        if (index < frame_pkg::VERSION_LENGTH) begin
            data = frame_pkg::VERSION_STRING[(frame_pkg::VERSION_LENGTH - 1 - index) * 8 +: 8];
        end else begin
            data = 8'h00; // Past the last character
        end
    end

    assign data_valid = enable;

endmodule

// ==== src/spi_subperipheral_if.sv ====
`timescale 1ns/1ps

interface spi_subperipheral_if;

    frame_pkg::spi_byte_t address;
    logic                 address_valid; // Level, held for the rest of the transaction
    frame_pkg::spi_byte_t copi;
    logic                 copi_valid;    // One clock per data byte
    frame_pkg::spi_byte_t cipo;
    logic                 cipo_valid;

    modport peripheral (
        output address,
        output address_valid,
        output copi,
        output copi_valid,
        input  cipo,
        input  cipo_valid
    );

    modport selector (
        input  address,
        input  address_valid,
        output cipo,
        output cipo_valid
    );

    modport testbench (
        input address,
        input address_valid,
        input copi,
        input copi_valid,
        input cipo,
        input cipo_valid
    );

endinterface

// ==== src/spi_subperipheral_selector.sv ====
`timescale 1ns/1ps

module spi_subperipheral_selector (
    spi_subperipheral_if.selector bus,
    output logic                 version_enable,
    input  frame_pkg::spi_byte_t version_data,
    input  logic                 version_data_valid
);

    always_comb begin
        bus.cipo       = 8'h00;
        bus.cipo_valid = 1'b0;
        version_enable = 1'b0;

        if (bus.address_valid) begin
            case (bus.address)
                frame_pkg::SPI_ADDR_CHIP_ID: begin
                    bus.cipo       = frame_pkg::CHIP_ID; // Constant, no block of its own
                    bus.cipo_valid = 1'b1;
                end
                frame_pkg::SPI_ADDR_VERSION: begin
                    version_enable = 1'b1;
                    bus.cipo       = version_data;
                    bus.cipo_valid = version_data_valid;
                end
                default: begin
                    // Unmapped addresses read back as nothing valid
                    bus.cipo_valid = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== src/top.sv ====
`timescale 1ns/1ps

module top #(
    parameter logic [15:0] H_ACTIVE = 16'd640,
    parameter logic [15:0] H_FRONT  = 16'd16,
    parameter logic [15:0] H_SYNC   = 16'd96,
    parameter logic [15:0] H_BACK   = 16'd48,
    parameter logic [15:0] V_ACTIVE = 16'd400,
    parameter logic [15:0] V_FRONT  = 16'd12,
    parameter logic [15:0] V_SYNC   = 16'd2,
    parameter logic [15:0] V_BACK   = 16'd35
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       spi_select,
    input  logic       spi_clock,
    input  logic       spi_data_in,
    output logic       spi_data_out,
    output logic       display_clock,
    output logic       display_hsync,
    output logic       display_vsync,
    output logic [3:0] display_y,
    output logic [2:0] display_cr,
    output logic [2:0] display_cb
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SPI path

    spi_subperipheral_if spi_bus ();

    logic                 version_enable;
    frame_pkg::spi_byte_t version_data;
    logic                 version_data_valid;

    spi_peripheral spi_peripheral (
        .clock        (clock),
        .rst          (rst),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .bus          (spi_bus.peripheral)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .bus                (spi_bus.selector),
        .version_enable     (version_enable),
        .version_data       (version_data),
        .version_data_valid (version_data_valid)
    );

    spi_register_version_string spi_register_version_string (
        .clock      (clock),
        .rst        (rst),
        .enable     (version_enable),
        .copi_valid (spi_bus.copi_valid), // Steps the character index
        .data       (version_data),
        .data_valid (version_data_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display

    display #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) display (
        .clock         (clock),
        .rst           (rst),
        .display_clock (display_clock),
        .hsync         (display_hsync),
        .vsync         (display_vsync),
        .y             (display_y),
        .cr            (display_cr),
        .cb            (display_cb)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = !clock;
    end

    // Release on a falling edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int NUM_TESTS = 4;
    localparam int MAX_BYTES = 6;
    localparam int SPI_HALF  = 4; // Clocks per SPI half period

    localparam logic [15:0] H_ACTIVE = 16'd8;
    localparam logic [15:0] H_FRONT  = 16'd2;
    localparam logic [15:0] H_SYNC   = 16'd2;
    localparam logic [15:0] H_BACK   = 16'd2;
    localparam logic [15:0] V_ACTIVE = 16'd4;
    localparam logic [15:0] V_FRONT  = 16'd1;
    localparam logic [15:0] V_SYNC   = 16'd1;
    localparam logic [15:0] V_BACK   = 16'd1;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES =
        (NUM_TESTS * MAX_BYTES * 8 * 8 + 2 * FRAME_CYCLES) * 2;

    logic       clock;
    logic       rst;
    logic       spi_select;
    logic       spi_clock;
    logic       spi_data_in;
    logic       spi_data_out;
    logic       display_clock;
    logic       display_hsync;
    logic       display_vsync;
    logic [3:0] display_y;
    logic [2:0] display_cr;
    logic [2:0] display_cb;

    int seed;
    int test_errors;
    int errors;
    int tests_run;
    int tests_failed;

    frame_pkg::spi_byte_t table_addr   [NUM_TESTS];
    int                   table_count  [NUM_TESTS];
    frame_pkg::spi_byte_t table_expect [NUM_TESTS][MAX_BYTES];

    tb_clock_gen clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) dut (
        .clock         (clock),
        .rst           (rst),
        .spi_select    (spi_select),
        .spi_clock     (spi_clock),
        .spi_data_in   (spi_data_in),
        .spi_data_out  (spi_data_out),
        .display_clock (display_clock),
        .display_hsync (display_hsync),
        .display_vsync (display_vsync),
        .display_y     (display_y),
        .display_cr    (display_cr),
        .display_cb    (display_cb)
    );

    bind top tb_top_sva #(.H_SYNC(H_SYNC)) sva (
        .clock        (clock),
        .rst          (rst),
        .spi_select   (spi_select),
        .spi_data_out (spi_data_out),
        .hsync        (display_hsync),
        .vsync        (display_vsync),
        .y            (display_y),
        .cr           (display_cr),
        .cb           (display_cb)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks

    task automatic check_byte(input string name, input frame_pkg::spi_byte_t got,
                              input frame_pkg::spi_byte_t expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic check_pixel(input logic [3:0] y_exp, input logic [2:0] cr_exp,
                               input logic [2:0] cb_exp);
        if (display_y !== y_exp) begin
            $display("FAILED display_y: got 0x%0h, expected 0x%0h", display_y, y_exp);
            test_errors++;
        end
        if (display_cr !== cr_exp) begin
            $display("FAILED display_cr: got 0x%0h, expected 0x%0h", display_cr, cr_exp);
            test_errors++;
        end
        if (display_cb !== cb_exp) begin
            $display("FAILED display_cb: got 0x%0h, expected 0x%0h", display_cb, cb_exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
            errors += test_errors;
        end
        test_errors = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SPI table and host

    // Character k of the version string, first character in the top byte
    function automatic frame_pkg::spi_byte_t version_char(input int k);
        if (k >= frame_pkg::VERSION_LENGTH) begin
            return 8'h00;
        end
        return frame_pkg::spi_byte_t'(frame_pkg::VERSION_STRING >>
                                      (8 * (frame_pkg::VERSION_LENGTH - 1 - k)));
    endfunction

    task automatic fill_entry(input int n, input frame_pkg::spi_byte_t addr, input int count);
        table_addr[n]  = addr;
        table_count[n] = count;
        for (int k = 0; k < MAX_BYTES; k++) begin
            if (addr == frame_pkg::SPI_ADDR_CHIP_ID) begin
                table_expect[n][k] = frame_pkg::CHIP_ID;
            end else if (addr == frame_pkg::SPI_ADDR_VERSION) begin
                table_expect[n][k] = version_char(k);
            end else begin
                table_expect[n][k] = 8'h00;
            end
        end
    endtask

    // Mode 0: data set while the SPI clock is low, both sides sample on the rising edge
    task automatic spi_transfer(input frame_pkg::spi_byte_t tx,
                                output frame_pkg::spi_byte_t rx);
        for (int b = 7; b >= 0; b--) begin
            spi_data_in = tx[b];
            repeat (SPI_HALF) @(negedge clock);
            rx[b]     = spi_data_out;
            spi_clock = 1'b1;
            repeat (SPI_HALF) @(negedge clock);
            spi_clock = 1'b0;
        end
    endtask

    task automatic run_transaction(input int n);
        frame_pkg::spi_byte_t rx;
        frame_pkg::spi_byte_t filler;
        spi_select = 1'b0;
        repeat (SPI_HALF) @(negedge clock);
        spi_transfer(table_addr[n], rx);
        check_byte("spi_data_out during address byte", rx, 8'h00);
        for (int k = 0; k < table_count[n]; k++) begin
            filler = $random(seed); // Written data is ignored by the register blocks
            spi_transfer(filler, rx);
            check_byte($sformatf("spi_data_out data byte %0d", k), rx, table_expect[n][k]);
        end
        repeat (SPI_HALF) @(negedge clock);
        spi_select = 1'b1;
        repeat (4 * SPI_HALF) @(negedge clock);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Display

    task automatic check_display();
        int          cycle;
        int          last_hfall;
        int          last_vfall;
        int          vfalls;
        logic [15:0] th;
        logic [15:0] tv;
        logic [15:0] sum;
        logic        prev_hsync;
        logic        prev_vsync;
        logic        prev_dclk;
        prev_vsync = display_vsync;
        @(negedge clock);
        while (!(prev_vsync && !display_vsync)) begin
            prev_vsync = display_vsync;
            @(negedge clock);
        end
        th         = 16'd0; // Outputs now show the first pixel of the vsync line
        tv         = V_ACTIVE + V_FRONT;
        cycle      = 0;
        last_hfall = -1;
        last_vfall = 0;
        vfalls     = 0;
        prev_hsync = 1'b1;
        prev_dclk  = 1'b0;
        while (cycle <= 2 * FRAME_CYCLES) begin
            sum = th + tv;
            if (cycle > 0) begin
                check_bit("display_clock", display_clock, !prev_dclk); // Half the clock rate
            end
            check_bit("display_hsync", display_hsync,
                      !(th >= H_ACTIVE + H_FRONT && th < H_ACTIVE + H_FRONT + H_SYNC));
            check_bit("display_vsync", display_vsync,
                      !(tv >= V_ACTIVE + V_FRONT && tv < V_ACTIVE + V_FRONT + V_SYNC));
            if (th < H_ACTIVE && tv < V_ACTIVE) begin
                check_pixel(th[3:0], tv[2:0], sum[2:0]);
            end else begin
                check_pixel(4'd0, 3'd0, 3'd0);
            end
            if (prev_hsync && !display_hsync) begin
                if (last_hfall >= 0) begin
                    check_count("hsync period in clocks", cycle - last_hfall, 2 * H_TOTAL);
                end
                last_hfall = cycle;
            end
            if (cycle > 0 && prev_vsync && !display_vsync) begin
                check_count("vsync period in clocks", cycle - last_vfall, FRAME_CYCLES);
                last_vfall = cycle;
                vfalls++;
            end
            prev_hsync = display_hsync;
            prev_vsync = display_vsync;
            prev_dclk  = display_clock;
            if (cycle % 2 == 1) begin // Each pixel lasts two clocks
                th = th + 16'd1;
                if (th == H_TOTAL) begin
                    th = 16'd0;
                    tv = (tv + 16'd1 == V_TOTAL) ? 16'd0 : tv + 16'd1;
                end
            end
            cycle++;
            @(negedge clock);
        end
        check_count("vsync falls over two frames", vfalls, 2);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence

    initial begin
        seed         = 32'h6883_fd64;
        spi_select   = 1'b0; // Selected during reset so the line shows the transmit register
        spi_clock    = 1'b0;
        spi_data_in  = 1'b0;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        fill_entry(0, frame_pkg::SPI_ADDR_CHIP_ID, 2);
        fill_entry(1, frame_pkg::SPI_ADDR_VERSION, 6);
        fill_entry(2, frame_pkg::SPI_ADDR_VERSION, 3); // Index must restart at the first char
        fill_entry(3, 8'h3C, 3);

        repeat (4) @(negedge clock);
        check_bit("spi_data_out", spi_data_out, 1'b0);
        check_bit("display_clock", display_clock, 1'b0);
        check_bit("display_hsync", display_hsync, 1'b1);
        check_bit("display_vsync", display_vsync, 1'b1);
        check_pixel(4'd0, 3'd0, 3'd0);
        finish_test("reset values");
        spi_select = 1'b1;

        wait (!rst);
        @(negedge clock);
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_transaction(n);
            finish_test($sformatf("SPI address 0x%02h with %0d data bytes",
                                  table_addr[n], table_count[n]));
        end

        check_display();
        finish_test("display timing and test pattern");

        check_count("assertion failure count", dut.sva.failures, 0);
        finish_test("bound assertions");

        $display("summary: %0d tests run, %0d with errors, %0d check errors",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verif/tb_top_sva.sv ====
`timescale 1ns/1ps

module tb_top_sva #(
    parameter logic [15:0] H_SYNC = 16'd96
) (
    input logic       clock,
    input logic       rst,
    input logic       spi_select,
    input logic       spi_data_out,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] y,
    input logic [2:0] cr,
    input logic [2:0] cb
);

    localparam int HSYNC_CYCLES = 2 * H_SYNC; // One display clock is two system clocks

    int failures = 0; // Failed assertions so far

    spi_out_released: assert property (
        @(posedge clock) disable iff (rst) spi_select |-> !spi_data_out
    ) else begin
        $error("spi_data_out is high while spi_select is high");
        failures++;
    end

    hsync_width: assert property (
        @(posedge clock) disable iff (rst)
        $fell(hsync) |-> !hsync [*HSYNC_CYCLES] ##1 hsync
    ) else begin
        $error("hsync low pulse is not %0d clocks long", HSYNC_CYCLES);
        failures++;
    end

    // Sync regions lie outside the active area, so the picture must be blank there
    blank_during_sync: assert property (
        @(posedge clock) disable iff (rst)
        (!hsync || !vsync) |-> (y == 4'd0 && cr == 3'd0 && cb == 3'd0)
    ) else begin
        $error("pixel lines are not zero during sync");
        failures++;
    end

endmodule

// ==== vlog.f ====
src/frame_pkg.sv
src/spi_subperipheral_if.sv
src/spi_peripheral.sv
src/spi_subperipheral_selector.sv
src/spi_register_version_string.sv
src/display.sv
src/top.sv
verif/tb_clock_gen.sv
verif/tb_top_sva.sv
verif/tb_top.sv
